// File: src/axi_apb_split_pkg.sv
// Shared definitions of the AXI address splitter
//   bus widths and the bridge address tag
//   AXI response codes
//   route and FSM state encodings

`default_nettype none

package axi_apb_split_pkg;

	// ******************************
	// Bus widths
	// ******************************
	localparam int addr_w = 32;
	localparam int data_w = 32;
	localparam int strb_w = 4;
	localparam int id_w = 4;

	// Top address bits compared against the tag
	localparam int tag_w = 4;
	localparam logic [tag_w-1:0] bridge_tag = 4'hf;

	// Outstanding requests per channel
	localparam int route_depth = 4;

	localparam logic [1:0] resp_okay = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// ******************************
	// Encodings
	// ******************************
	typedef enum logic {
		route_axi = 1'b0,
		route_apb = 1'b1
	} route_t;

	typedef enum logic [2:0] {
		st_idle,
		st_wait,
		st_pass,
		st_aw_done,
		st_w_done
	} steer_state_t;

	typedef enum logic [1:0] {
		ap_idle,
		ap_setup,
		ap_access,
		ap_resp
	} apb_state_t;

endpackage

`default_nettype wire

// File: src/route_fifo.sv
// Route FIFO
//   circular buffer of route bits, one entry per accepted request
//   occupancy counter for full and empty

`default_nettype none

module route_fifo
#(
	parameter int depth = axi_apb_split_pkg::route_depth
)
(
	input  wire logic munoc_port_30,
	input  wire logic munoc_port_16,
	input  wire logic push,
	input  wire axi_apb_split_pkg::route_t push_route,
	input  wire logic pop,
	output axi_apb_split_pkg::route_t head_route,
	output logic full,
	output logic empty
);
	import axi_apb_split_pkg::*;

	localparam int ptr_w = $clog2(depth);
	localparam int cnt_w = $clog2(depth + 1);

	route_t mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;

	// Wraps at depth, so depth need not be a power of two
	function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] ptr);
		if (ptr == ptr_w'(depth - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	always_ff @(posedge munoc_port_30)
	begin
		if (push)
			mem[wr_ptr] <= push_route;
	end

	always_ff @(posedge munoc_port_30 or negedge munoc_port_16)
	begin
		if (!munoc_port_16)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop)
				rd_ptr <= ptr_next(rd_ptr);
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	assign head_route = mem[rd_ptr];
	assign full = (count == cnt_w'(depth));
	assign empty = (count == '0);

	assert property (@(posedge munoc_port_30) disable iff (!munoc_port_16) push |-> !full)
		else $error("route_fifo: push while full");
	assert property (@(posedge munoc_port_30) disable iff (!munoc_port_16) pop |-> !empty)
		else $error("route_fifo: pop while empty");

endmodule

`default_nettype wire

// File: src/write_path.sv
// Write path of the splitter
//   tag decode and AW/W steering FSM
//   route FIFO and B response selection

`default_nettype none

module write_path
(
	input  wire logic munoc_port_30,
	input  wire logic munoc_port_16,
	// Upstream
	input  wire logic [axi_apb_split_pkg::addr_w-1:0] aw_addr,
	input  wire logic aw_valid,
	output logic aw_ready,
	input  wire logic w_valid,
	output logic w_ready,
	output logic [axi_apb_split_pkg::id_w-1:0] b_id,
	output logic [1:0] b_resp,
	output logic b_valid,
	input  wire logic b_ready,
	// Downstream AXI
	output logic m_aw_valid,
	input  wire logic m_aw_ready,
	output logic m_w_valid,
	input  wire logic m_w_ready,
	input  wire logic [axi_apb_split_pkg::id_w-1:0] m_b_id,
	input  wire logic [1:0] m_b_resp,
	input  wire logic m_b_valid,
	output logic m_b_ready,
	// Bridge
	output logic br_aw_valid,
	input  wire logic br_aw_ready,
	output logic br_w_valid,
	input  wire logic br_w_ready,
	input  wire logic [axi_apb_split_pkg::id_w-1:0] br_b_id,
	input  wire logic [1:0] br_b_resp,
	input  wire logic br_b_valid,
	output logic br_b_ready
);
	import axi_apb_split_pkg::*;

	steer_state_t state;
	route_t route_q;
	route_t head_route;
	logic fifo_full;
	logic fifo_empty;
	logic to_apb;
	logic aw_open;
	logic w_open;
	logic aw_hs;
	logic w_hs;
	logic b_hs;

	assign to_apb = (aw_addr[addr_w-1 -: tag_w] == bridge_tag);

	assign aw_hs = aw_valid & aw_ready;
	assign w_hs = w_valid & w_ready;
	assign b_hs = b_valid & b_ready;

	// ******************************
	// Steering FSM
	// ******************************
	always_ff @(posedge munoc_port_30 or negedge munoc_port_16)
	begin
		if (!munoc_port_16)
		begin
			state <= st_idle;
			route_q <= route_axi;
		end
		else
		begin
			case (state)
				st_idle:
					if (aw_valid)
					begin
						route_q <= to_apb ? route_apb : route_axi;
						state <= fifo_full ? st_wait : st_pass;
					end
				st_wait:
					if (!fifo_full)
						state <= st_pass;
				st_pass:
					if (aw_hs && w_hs)
						state <= st_idle;
					else if (aw_hs)
						state <= st_aw_done;
					else if (w_hs)
						state <= st_w_done;
				st_aw_done:
					if (w_hs)
						state <= st_idle;
				st_w_done:
					if (aw_hs)
						state <= st_idle;
				default:
					state <= st_idle;
			endcase
		end
	end

	// A channel stays open until its own handshake
	assign aw_open = (state == st_pass) || (state == st_w_done);
	assign w_open = (state == st_pass) || (state == st_aw_done);

	always_comb
	begin
		m_aw_valid = 1'b0;
		m_w_valid = 1'b0;
		br_aw_valid = 1'b0;
		br_w_valid = 1'b0;
		if (route_q == route_apb)
		begin
			br_aw_valid = aw_open & aw_valid;
			br_w_valid = w_open & w_valid;
			aw_ready = aw_open & br_aw_ready;
			w_ready = w_open & br_w_ready;
		end
		else
		begin
			m_aw_valid = aw_open & aw_valid;
			m_w_valid = w_open & w_valid;
			aw_ready = aw_open & m_aw_ready;
			w_ready = w_open & m_w_ready;
		end
	end

	route_fifo u_route_fifo
	(
		.munoc_port_30(munoc_port_30),
		.munoc_port_16(munoc_port_16),
		.push(aw_hs),
		.push_route(route_q),
		.pop(b_hs),
		.head_route(head_route),
		.full(fifo_full),
		.empty(fifo_empty)
	);

	// ******************************
	// B selection by FIFO head
	// ******************************
	assign b_valid = !fifo_empty && ((head_route == route_apb) ? br_b_valid : m_b_valid);
	assign b_id = (head_route == route_apb) ? br_b_id : m_b_id;
	assign b_resp = (head_route == route_apb) ? br_b_resp : m_b_resp;
	assign m_b_ready = !fifo_empty && (head_route == route_axi) && b_ready;
	assign br_b_ready = !fifo_empty && (head_route == route_apb) && b_ready;

	assert property (@(posedge munoc_port_30) disable iff (!munoc_port_16)
		b_valid && !b_ready |=> b_valid && $stable(b_id) && $stable(b_resp))
		else $error("write_path: B response changed before b_ready");

endmodule

`default_nettype wire

// File: src/read_path.sv
// Read path of the splitter
//   tag decode and AR steering FSM
//   route FIFO and R response selection

`default_nettype none

module read_path
(
	input  wire logic munoc_port_30,
	input  wire logic munoc_port_16,
	// Upstream
	input  wire logic [axi_apb_split_pkg::addr_w-1:0] ar_addr,
	input  wire logic ar_valid,
	output logic ar_ready,
	output logic [axi_apb_split_pkg::id_w-1:0] r_id,
	output logic [axi_apb_split_pkg::data_w-1:0] r_data,
	output logic [1:0] r_resp,
	output logic r_valid,
	input  wire logic r_ready,
	// Downstream AXI
	output logic m_ar_valid,
	input  wire logic m_ar_ready,
	input  wire logic [axi_apb_split_pkg::id_w-1:0] m_r_id,
	input  wire logic [axi_apb_split_pkg::data_w-1:0] m_r_data,
	input  wire logic [1:0] m_r_resp,
	input  wire logic m_r_valid,
	output logic m_r_ready,
	// Bridge
	output logic br_ar_valid,
	input  wire logic br_ar_ready,
	input  wire logic [axi_apb_split_pkg::id_w-1:0] br_r_id,
	input  wire logic [axi_apb_split_pkg::data_w-1:0] br_r_data,
	input  wire logic [1:0] br_r_resp,
	input  wire logic br_r_valid,
	output logic br_r_ready
);
	import axi_apb_split_pkg::*;

	steer_state_t state;
	route_t route_q;
	route_t head_route;
	logic fifo_full;
	logic fifo_empty;
	logic to_apb;
	logic ar_open;
	logic ar_hs;
	logic r_hs;
	logic head_apb;

	assign to_apb = (ar_addr[addr_w-1 -: tag_w] == bridge_tag);

	assign ar_hs = ar_valid & ar_ready;
	assign r_hs = r_valid & r_ready;

	always_ff @(posedge munoc_port_30 or negedge munoc_port_16)
	begin
		if (!munoc_port_16)
		begin
			state <= st_idle;
			route_q <= route_axi;
		end
		else
		begin
			case (state)
				st_idle:
					if (ar_valid)
					begin
						route_q <= to_apb ? route_apb : route_axi;
						state <= fifo_full ? st_wait : st_pass;
					end
				st_wait:
					if (!fifo_full)
						state <= st_pass;
				st_pass:
					if (ar_hs)
						state <= st_idle;
				default:
					state <= st_idle;
			endcase
		end
	end

	assign ar_open = (state == st_pass);
	assign m_ar_valid = ar_open && ar_valid && (route_q == route_axi);
	assign br_ar_valid = ar_open && ar_valid && (route_q == route_apb);
	assign ar_ready = ar_open && ((route_q == route_apb) ? br_ar_ready : m_ar_ready);

	route_fifo u_route_fifo
	(
		.munoc_port_30(munoc_port_30),
		.munoc_port_16(munoc_port_16),
		.push(ar_hs),
		.push_route(route_q),
		.pop(r_hs),
		.head_route(head_route),
		.full(fifo_full),
		.empty(fifo_empty)
	);

	// R selection by FIFO head
	assign head_apb = (head_route == route_apb);
	assign r_valid = !fifo_empty && (head_apb ? br_r_valid : m_r_valid);
	assign r_id = head_apb ? br_r_id : m_r_id;
	assign r_data = head_apb ? br_r_data : m_r_data;
	assign r_resp = head_apb ? br_r_resp : m_r_resp;
	assign m_r_ready = !fifo_empty && !head_apb && r_ready;
	assign br_r_ready = !fifo_empty && head_apb && r_ready;

	// No read accepted with all route slots taken
	assert property (@(posedge munoc_port_30) disable iff (!munoc_port_16)
		fifo_full |-> !ar_ready)
		else $error("read_path: ar_ready high with route FIFO full");

endmodule

`default_nettype wire

// File: src/apb_bridge.sv
// AXI to APB bridge
//   one single-beat request at a time, write before read
//   APB setup and access phases
//   B or R response held until accepted

`default_nettype none

module apb_bridge
(
	input  wire logic munoc_port_30,
	input  wire logic munoc_port_16,
	// Requests
	input  wire logic [axi_apb_split_pkg::id_w-1:0] aw_id,
	input  wire logic [axi_apb_split_pkg::addr_w-1:0] aw_addr,
	input  wire logic aw_valid,
	output logic aw_ready,
	input  wire logic [axi_apb_split_pkg::data_w-1:0] w_data,
	input  wire logic w_valid,
	output logic w_ready,
	input  wire logic [axi_apb_split_pkg::id_w-1:0] ar_id,
	input  wire logic [axi_apb_split_pkg::addr_w-1:0] ar_addr,
	input  wire logic ar_valid,
	output logic ar_ready,
	// Responses
	output logic [axi_apb_split_pkg::id_w-1:0] b_id,
	output logic [1:0] b_resp,
	output logic b_valid,
	input  wire logic b_ready,
	output logic [axi_apb_split_pkg::id_w-1:0] r_id,
	output logic [axi_apb_split_pkg::data_w-1:0] r_data,
	output logic [1:0] r_resp,
	output logic r_valid,
	input  wire logic r_ready,
	// APB
	output logic [axi_apb_split_pkg::addr_w-1:0] paddr,
	output logic pwrite,
	output logic psel,
	output logic penable,
	output logic [axi_apb_split_pkg::data_w-1:0] pwdata,
	input  wire logic [axi_apb_split_pkg::data_w-1:0] prdata,
	input  wire logic pready,
	input  wire logic pslverr
);
	import axi_apb_split_pkg::*;

	apb_state_t state;
	logic write_q;
	logic [id_w-1:0] id_q;
	logic [addr_w-1:0] addr_q;
	logic [data_w-1:0] data_q;
	logic [1:0] resp_q;
	logic take_write;
	logic take_read;

	// Write needs AW and W together and wins over a read
	assign take_write = (state == ap_idle) && aw_valid && w_valid;
	assign take_read = (state == ap_idle) && ar_valid && !(aw_valid && w_valid);

	assign aw_ready = take_write;
	assign w_ready = take_write;
	assign ar_ready = take_read;

	always_ff @(posedge munoc_port_30 or negedge munoc_port_16)
	begin
		if (!munoc_port_16)
		begin
			state <= ap_idle;
			write_q <= 1'b0;
		end
		else
		begin
			case (state)
				ap_idle:
					if (take_write || take_read)
					begin
						write_q <= take_write;
						state <= ap_setup;
					end
				ap_setup:
					state <= ap_access;
				ap_access:
					if (pready)
						state <= ap_resp;
				ap_resp:
					if (write_q ? b_ready : r_ready)
						state <= ap_idle;
				default:
					state <= ap_idle;
			endcase
		end
	end

	// Request and response payload
	always_ff @(posedge munoc_port_30)
	begin
		if (take_write)
		begin
			id_q <= aw_id;
			addr_q <= aw_addr;
			data_q <= w_data;
		end
		else if (take_read)
		begin
			id_q <= ar_id;
			addr_q <= ar_addr;
		end
		else if ((state == ap_access) && pready)
		begin
			resp_q <= pslverr ? resp_slverr : resp_okay;
			if (!write_q)
				data_q <= prdata;
		end
	end

	assign psel = (state == ap_setup) || (state == ap_access);
	assign penable = (state == ap_access);
	assign paddr = addr_q;
	assign pwrite = write_q;
	assign pwdata = data_q;

	assign b_valid = (state == ap_resp) && write_q;
	assign b_id = id_q;
	assign b_resp = resp_q;
	assign r_valid = (state == ap_resp) && !write_q;
	assign r_id = id_q;
	assign r_data = data_q;
	assign r_resp = resp_q;

	assert property (@(posedge munoc_port_30) disable iff (!munoc_port_16)
		penable |-> psel && $past(psel))
		else $error("apb_bridge: penable without setup cycle");
	assert property (@(posedge munoc_port_30) disable iff (!munoc_port_16)
		psel && penable |-> $stable(paddr) && $stable(pwrite))
		else $error("apb_bridge: paddr changed during access");

endmodule

`default_nettype wire

// File: src/axi_apb_split.sv
// Top level of the AXI address splitter
//   upstream AXI, downstream AXI and APB ports
//   write path, read path and APB bridge instances

`default_nettype none

module axi_apb_split
(
	input  wire logic munoc_port_30,
	input  wire logic munoc_port_16,
	// Upstream AXI
	input  wire logic [axi_apb_split_pkg::id_w-1:0] aw_id,
	input  wire logic [axi_apb_split_pkg::addr_w-1:0] aw_addr,
	input  wire logic aw_valid,
	output logic aw_ready,
	input  wire logic [axi_apb_split_pkg::data_w-1:0] w_data,
	input  wire logic [axi_apb_split_pkg::strb_w-1:0] w_strb,
	input  wire logic w_valid,
	output logic w_ready,
	output logic [axi_apb_split_pkg::id_w-1:0] b_id,
	output logic [1:0] b_resp,
	output logic b_valid,
	input  wire logic b_ready,
	input  wire logic [axi_apb_split_pkg::id_w-1:0] ar_id,
	input  wire logic [axi_apb_split_pkg::addr_w-1:0] ar_addr,
	input  wire logic ar_valid,
	output logic ar_ready,
	output logic [axi_apb_split_pkg::id_w-1:0] r_id,
	output logic [axi_apb_split_pkg::data_w-1:0] r_data,
	output logic [1:0] r_resp,
	output logic r_valid,
	input  wire logic r_ready,
	// Downstream AXI
	output logic [axi_apb_split_pkg::id_w-1:0] m_aw_id,
	output logic [axi_apb_split_pkg::addr_w-1:0] m_aw_addr,
	output logic m_aw_valid,
	input  wire logic m_aw_ready,
	output logic [axi_apb_split_pkg::data_w-1:0] m_w_data,
	output logic [axi_apb_split_pkg::strb_w-1:0] m_w_strb,
	output logic m_w_valid,
	input  wire logic m_w_ready,
	input  wire logic [axi_apb_split_pkg::id_w-1:0] m_b_id,
	input  wire logic [1:0] m_b_resp,
	input  wire logic m_b_valid,
	output logic m_b_ready,
	output logic [axi_apb_split_pkg::id_w-1:0] m_ar_id,
	output logic [axi_apb_split_pkg::addr_w-1:0] m_ar_addr,
	output logic m_ar_valid,
	input  wire logic m_ar_ready,
	input  wire logic [axi_apb_split_pkg::id_w-1:0] m_r_id,
	input  wire logic [axi_apb_split_pkg::data_w-1:0] m_r_data,
	input  wire logic [1:0] m_r_resp,
	input  wire logic m_r_valid,
	output logic m_r_ready,
	// APB
	output logic [axi_apb_split_pkg::addr_w-1:0] paddr,
	output logic pwrite,
	output logic psel,
	output logic penable,
	output logic [axi_apb_split_pkg::data_w-1:0] pwdata,
	input  wire logic [axi_apb_split_pkg::data_w-1:0] prdata,
	input  wire logic pready,
	input  wire logic pslverr
);
	import axi_apb_split_pkg::*;

	// ******************************
	// Path to bridge wires
	// ******************************
	logic br_aw_valid;
	logic br_aw_ready;
	logic br_w_valid;
	logic br_w_ready;
	logic [id_w-1:0] br_b_id;
	logic [1:0] br_b_resp;
	logic br_b_valid;
	logic br_b_ready;
	logic br_ar_valid;
	logic br_ar_ready;
	logic [id_w-1:0] br_r_id;
	logic [data_w-1:0] br_r_data;
	logic [1:0] br_r_resp;
	logic br_r_valid;
	logic br_r_ready;

	// Request payload goes straight downstream, only valids are steered
	assign m_aw_id = aw_id;
	assign m_aw_addr = aw_addr;
	assign m_w_data = w_data;
	assign m_w_strb = w_strb;
	assign m_ar_id = ar_id;
	assign m_ar_addr = ar_addr;

	// Path ports carry the same names as the top-level signals
	write_path u_write_path
	(
		.*
	);

	read_path u_read_path
	(
		.*
	);

	apb_bridge u_apb_bridge
	(
		.aw_valid(br_aw_valid),
		.aw_ready(br_aw_ready),
		.w_valid(br_w_valid),
		.w_ready(br_w_ready),
		.b_id(br_b_id),
		.b_resp(br_b_resp),
		.b_valid(br_b_valid),
		.b_ready(br_b_ready),
		.ar_valid(br_ar_valid),
		.ar_ready(br_ar_ready),
		.r_id(br_r_id),
		.r_data(br_r_data),
		.r_resp(br_r_resp),
		.r_valid(br_r_valid),
		.r_ready(br_r_ready),
		.*
	);

endmodule

`default_nettype wire

// File: testbench/tb_slave_models.sv
// Slave models for the splitter testbench
//   downstream AXI slave with in-order B and R queues
//   APB slave with a small word memory
//   both can hold back their responses

`default_nettype none

module axi_slave_model
(
	input  wire logic munoc_port_30,
	input  wire logic munoc_port_16,
	input  wire logic hold,
	input  wire logic [axi_apb_split_pkg::id_w-1:0] aw_id,
	input  wire logic aw_valid,
	output logic aw_ready,
	input  wire logic w_valid,
	output logic w_ready,
	output logic [axi_apb_split_pkg::id_w-1:0] b_id,
	output logic [1:0] b_resp,
	output logic b_valid,
	input  wire logic b_ready,
	input  wire logic [axi_apb_split_pkg::id_w-1:0] ar_id,
	input  wire logic [axi_apb_split_pkg::addr_w-1:0] ar_addr,
	input  wire logic ar_valid,
	output logic ar_ready,
	output logic [axi_apb_split_pkg::id_w-1:0] r_id,
	output logic [axi_apb_split_pkg::data_w-1:0] r_data,
	output logic [1:0] r_resp,
	output logic r_valid,
	input  wire logic r_ready
);
	import axi_apb_split_pkg::*;

	localparam logic [data_w-1:0] data_mask = 32'h5a5a5a5a;

	logic [id_w-1:0] b_fifo [$];
	logic [id_w+data_w-1:0] r_fifo [$];
	int w_count;

	assign aw_ready = 1'b1;
	assign w_ready = 1'b1;
	assign ar_ready = 1'b1;
	assign b_resp = resp_okay;
	assign r_resp = resp_okay;

	always @(posedge munoc_port_30 or negedge munoc_port_16)
	begin
		if (!munoc_port_16)
		begin
			b_valid <= 1'b0;
			b_id <= '0;
			r_valid <= 1'b0;
			r_id <= '0;
			r_data <= '0;
			w_count = 0;
			b_fifo.delete();
			r_fifo.delete();
		end
		else
		begin
			if (aw_valid && aw_ready)
				b_fifo.push_back(aw_id);
			if (w_valid && w_ready)
				w_count++;
			if (ar_valid && ar_ready)
				r_fifo.push_back({ar_id, ar_addr ^ data_mask});
			// A raised valid stays up until accepted, hold only delays the next one
			if (b_valid && b_ready)
				b_valid <= 1'b0;
			else if (!b_valid && !hold && b_fifo.size() > 0 && w_count > 0)
			begin
				b_id <= b_fifo.pop_front();
				w_count--;
				b_valid <= 1'b1;
			end
			if (r_valid && r_ready)
				r_valid <= 1'b0;
			else if (!r_valid && !hold && r_fifo.size() > 0)
			begin
				{r_id, r_data} <= r_fifo.pop_front();
				r_valid <= 1'b1;
			end
		end
	end

endmodule

module apb_slave_model
(
	input  wire logic munoc_port_30,
	input  wire logic hold,
	input  wire logic [axi_apb_split_pkg::addr_w-1:0] paddr,
	input  wire logic pwrite,
	input  wire logic psel,
	input  wire logic penable,
	input  wire logic [axi_apb_split_pkg::data_w-1:0] pwdata,
	output logic [axi_apb_split_pkg::data_w-1:0] prdata,
	output logic pready,
	output logic pslverr
);
	logic [31:0] mem [64];

	initial
	begin
		for (int i = 0; i < 64; i++)
			mem[i] = 32'hc3a50000 + i;
	end

	assign pready = !hold;
	assign pslverr = psel && penable && (paddr[7:0] == 8'hfc);
	assign prdata = mem[paddr[7:2]];

	// Failed writes leave the memory untouched
	always @(posedge munoc_port_30)
	begin
		if (psel && penable && pready && pwrite && !pslverr)
			mem[paddr[7:2]] <= pwdata;
	end

endmodule

`default_nettype wire

// File: testbench/tb_axi_apb_split.sv
// Testbench of the AXI address splitter
//   clock, reset and request tasks
//   expected response queues and concurrent checks
//   timeout and result report

`default_nettype none

module tb_axi_apb_split;
	import axi_apb_split_pkg::*;

	localparam int num_tests = 6;
	localparam int timeout_cycles = num_tests * 200 + 100;
	localparam logic [data_w-1:0] data_mask = 32'h5a5a5a5a;

	logic munoc_port_30;
	logic munoc_port_16;
	logic [id_w-1:0] aw_id;
	logic [addr_w-1:0] aw_addr;
	logic aw_valid;
	logic aw_ready;
	logic [data_w-1:0] w_data;
	logic [strb_w-1:0] w_strb;
	logic w_valid;
	logic w_ready;
	logic [id_w-1:0] b_id;
	logic [1:0] b_resp;
	logic b_valid;
	logic b_ready;
	logic [id_w-1:0] ar_id;
	logic [addr_w-1:0] ar_addr;
	logic ar_valid;
	logic ar_ready;
	logic [id_w-1:0] r_id;
	logic [data_w-1:0] r_data;
	logic [1:0] r_resp;
	logic r_valid;
	logic r_ready;
	logic [id_w-1:0] m_aw_id;
	logic [addr_w-1:0] m_aw_addr;
	logic m_aw_valid;
	logic m_aw_ready;
	logic [data_w-1:0] m_w_data;
	logic [strb_w-1:0] m_w_strb;
	logic m_w_valid;
	logic m_w_ready;
	logic [id_w-1:0] m_b_id;
	logic [1:0] m_b_resp;
	logic m_b_valid;
	logic m_b_ready;
	logic [id_w-1:0] m_ar_id;
	logic [addr_w-1:0] m_ar_addr;
	logic m_ar_valid;
	logic m_ar_ready;
	logic [id_w-1:0] m_r_id;
	logic [data_w-1:0] m_r_data;
	logic [1:0] m_r_resp;
	logic m_r_valid;
	logic m_r_ready;
	logic [addr_w-1:0] paddr;
	logic pwrite;
	logic psel;
	logic penable;
	logic [data_w-1:0] pwdata;
	logic [data_w-1:0] prdata;
	logic pready;
	logic pslverr;

	logic axi_hold;
	logic apb_hold;
	logic no_apb;
	logic [31:0] lcg_state = 32'h3b90;
	logic [addr_w-1:0] wr_addr [3];
	logic [data_w-1:0] apb_ref [int];
	logic [addr_w-1:0] exp_paddr;
	logic [data_w-1:0] exp_pwdata;
	logic [addr_w-1:0] exp_w_addr;
	logic [data_w-1:0] exp_w_data;
	logic [strb_w-1:0] exp_w_strb;

	// Expected responses in request order
	// Queue heads are copied out on the falling edge
	logic [id_w+1:0] b_exp_q [$];
	logic [id_w+data_w+1:0] r_exp_q [$];
	int b_pending;
	int r_pending;
	logic [id_w-1:0] b_head_id;
	logic [1:0] b_head_resp;
	logic [id_w-1:0] r_head_id;
	logic [data_w-1:0] r_head_data;
	logic [1:0] r_head_resp;
	logic [data_w-1:0] r_data_prev;
	int rd_outstanding;

	int err_count;
	int err_mark;
	int test_count;
	int fail_count;
	int cycle_count;

	axi_apb_split u_axi_apb_split
	(
		.*
	);

	axi_slave_model u_axi_slave
	(
		.munoc_port_30(munoc_port_30),
		.munoc_port_16(munoc_port_16),
		.hold(axi_hold),
		.aw_id(m_aw_id),
		.aw_valid(m_aw_valid),
		.aw_ready(m_aw_ready),
		.w_valid(m_w_valid),
		.w_ready(m_w_ready),
		.b_id(m_b_id),
		.b_resp(m_b_resp),
		.b_valid(m_b_valid),
		.b_ready(m_b_ready),
		.ar_id(m_ar_id),
		.ar_addr(m_ar_addr),
		.ar_valid(m_ar_valid),
		.ar_ready(m_ar_ready),
		.r_id(m_r_id),
		.r_data(m_r_data),
		.r_resp(m_r_resp),
		.r_valid(m_r_valid),
		.r_ready(m_r_ready)
	);

	apb_slave_model u_apb_slave
	(
		.munoc_port_30(munoc_port_30),
		.hold(apb_hold),
		.paddr(paddr),
		.pwrite(pwrite),
		.psel(psel),
		.penable(penable),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	initial
	begin
		munoc_port_30 = 1'b0;
		forever
			#4 munoc_port_30 = ~munoc_port_30;
	end

	// ******************************
	// Helpers
	// ******************************
	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Tagged addresses keep bits 2:0 clear and never hit offset FC
	function automatic logic [addr_w-1:0] make_addr(input logic to_bridge);
		logic [31:0] rnd;
		logic [tag_w-1:0] top;
		rnd = next_random();
		if (to_bridge)
			return {bridge_tag, rnd[27:8], rnd[7:3], 3'b000};
		top = rnd[31:28];
		if (top == bridge_tag)
			top = 4'h7;
		return {top, rnd[27:2], 2'b00};
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		$display("** Error %s: got %h expected %h", name, got, expected);
		err_count++;
	endtask

	task automatic report_failure(input string what);
		$display("Check failed: %s", what);
		err_count++;
	endtask

	task automatic send_write(input logic [id_w-1:0] id, input logic [addr_w-1:0] addr,
		input logic [data_w-1:0] data);
		logic to_bridge;
		logic bad_offset;
		logic aw_go;
		logic w_go;
		to_bridge = (addr[addr_w-1 -: tag_w] == bridge_tag);
		bad_offset = to_bridge && (addr[7:0] == 8'hfc);
		b_exp_q.push_back({id, bad_offset ? resp_slverr : resp_okay});
		if (to_bridge)
		begin
			exp_paddr = addr;
			exp_pwdata = data;
			if (!bad_offset)
				apb_ref[addr[7:2]] = data;
		end
		exp_w_addr = addr;
		exp_w_data = data;
		exp_w_strb = strb_w'(next_random());
		aw_id = id;
		aw_addr = addr;
		w_data = data;
		w_strb = exp_w_strb;
		aw_valid = 1'b1;
		w_valid = 1'b1;
		while (aw_valid || w_valid)
		begin
			@(negedge munoc_port_30);
			aw_go = aw_valid && aw_ready;
			w_go = w_valid && w_ready;
			@(posedge munoc_port_30);
			#1;
			if (aw_go)
				aw_valid = 1'b0;
			if (w_go)
				w_valid = 1'b0;
		end
	endtask

	task automatic send_read(input logic [id_w-1:0] id, input logic [addr_w-1:0] addr);
		logic go;
		if (addr[addr_w-1 -: tag_w] == bridge_tag)
			r_exp_q.push_back({id, apb_ref[addr[7:2]],
				(addr[7:0] == 8'hfc) ? resp_slverr : resp_okay});
		else
			r_exp_q.push_back({id, addr ^ data_mask, resp_okay});
		ar_id = id;
		ar_addr = addr;
		ar_valid = 1'b1;
		go = 1'b0;
		while (!go)
		begin
			@(negedge munoc_port_30);
			go = ar_ready;
			@(posedge munoc_port_30);
			#1;
		end
		ar_valid = 1'b0;
	endtask

	task automatic drain_responses();
		while (b_exp_q.size() > 0 || r_exp_q.size() > 0)
			@(posedge munoc_port_30);
		#1;
	endtask

	task automatic finish_test(input string name);
		int errs;
		repeat (2) @(posedge munoc_port_30);
		#1;
		errs = err_count - err_mark;
		test_count++;
		if (errs == 0)
			$display("test %0d %s: ok", test_count, name);
		else
		begin
			$display("test %0d %s: %0d errors", test_count, name, errs);
			fail_count++;
		end
		err_mark = err_count;
	endtask

	// ******************************
	// Scoreboard bookkeeping
	// ******************************
	always @(posedge munoc_port_30)
	begin
		if (munoc_port_16)
		begin
			if (b_valid && b_ready && b_exp_q.size() > 0)
				void'(b_exp_q.pop_front());
			if (r_valid && r_ready && r_exp_q.size() > 0)
				void'(r_exp_q.pop_front());
			if (ar_valid && ar_ready)
				rd_outstanding++;
			if (r_valid && r_ready)
				rd_outstanding--;
		end
		r_data_prev <= r_data;
	end

	always @(negedge munoc_port_30)
	begin
		b_pending = b_exp_q.size();
		r_pending = r_exp_q.size();
		if (b_pending > 0)
			{b_head_id, b_head_resp} = b_exp_q[0];
		if (r_pending > 0)
			{r_head_id, r_head_data, r_head_resp} = r_exp_q[0];
	end

	always @(posedge munoc_port_30)
	begin
		cycle_count++;
		if (cycle_count > timeout_cycles)
		begin
			$display("Timeout after %0d cycles, a handshake or response never came",
				timeout_cycles);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// ******************************
	// Checks
	// ******************************
	assert property (@(posedge munoc_port_30) !munoc_port_16 || $past(!munoc_port_16) |->
		!(b_valid || r_valid || m_aw_valid || m_w_valid || m_ar_valid || psel || penable ||
		aw_ready || w_ready || ar_ready))
		else report_failure("valid, ready or APB select high during or just after reset");
	assert property (@(posedge munoc_port_30) disable iff (!munoc_port_16)
		psel && penable && pready && pwrite |-> paddr == exp_paddr)
		else report_mismatch("paddr", $sampled(paddr), $sampled(exp_paddr));
	assert property (@(posedge munoc_port_30) disable iff (!munoc_port_16)
		psel && penable && pready && pwrite |-> pwdata == exp_pwdata)
		else report_mismatch("pwdata", $sampled(pwdata), $sampled(exp_pwdata));

	assert property (@(posedge munoc_port_30) disable iff (!munoc_port_16)
		b_valid |-> b_pending > 0)
		else report_failure("B response with no write outstanding");
	assert property (@(posedge munoc_port_30) disable iff (!munoc_port_16)
		b_valid && b_ready |-> b_id == b_head_id)
		else report_mismatch("b_id", $sampled(b_id), $sampled(b_head_id));
	assert property (@(posedge munoc_port_30) disable iff (!munoc_port_16)
		b_valid && b_ready |-> b_resp == b_head_resp)
		else report_mismatch("b_resp", $sampled(b_resp), $sampled(b_head_resp));

	assert property (@(posedge munoc_port_30) disable iff (!munoc_port_16)
		r_valid |-> r_pending > 0)
		else report_failure("R response with no read outstanding");
	assert property (@(posedge munoc_port_30) disable iff (!munoc_port_16)
		r_valid && r_ready |-> r_id == r_head_id)
		else report_mismatch("r_id", $sampled(r_id), $sampled(r_head_id));
	assert property (@(posedge munoc_port_30) disable iff (!munoc_port_16)
		r_valid && r_ready |-> r_data == r_head_data)
		else report_mismatch("r_data", $sampled(r_data), $sampled(r_head_data));
	assert property (@(posedge munoc_port_30) disable iff (!munoc_port_16)
		r_valid && r_ready |-> r_resp == r_head_resp)
		else report_mismatch("r_resp", $sampled(r_resp), $sampled(r_head_resp));

	// Untagged traffic stays off APB and tagged traffic stays off downstream AXI
	assert property (@(posedge munoc_port_30) disable iff (!munoc_port_16)
		no_apb |-> !psel)
		else report_failure("APB select raised by an untagged request");
	assert property (@(posedge munoc_port_30) disable iff (!munoc_port_16)
		m_aw_valid |-> m_aw_addr[addr_w-1 -: tag_w] != bridge_tag)
		else report_failure("tagged write reached the downstream port");
	assert property (@(posedge munoc_port_30) disable iff (!munoc_port_16)
		m_ar_valid |-> m_ar_addr[addr_w-1 -: tag_w] != bridge_tag)
		else report_failure("tagged read reached the downstream port");

	// Downstream write payload unchanged
	assert property (@(posedge munoc_port_30) disable iff (!munoc_port_16)
		m_aw_valid |-> m_aw_addr == exp_w_addr)
		else report_mismatch("m_aw_addr", $sampled(m_aw_addr), $sampled(exp_w_addr));
	assert property (@(posedge munoc_port_30) disable iff (!munoc_port_16)
		m_w_valid |-> m_w_data == exp_w_data)
		else report_mismatch("m_w_data", $sampled(m_w_data), $sampled(exp_w_data));
	assert property (@(posedge munoc_port_30) disable iff (!munoc_port_16)
		m_w_valid |-> m_w_strb == exp_w_strb)
		else report_mismatch("m_w_strb", $sampled(m_w_strb), $sampled(exp_w_strb));

	assert property (@(posedge munoc_port_30) disable iff (!munoc_port_16)
		r_valid && !r_ready |=> r_valid)
		else report_failure("r_valid dropped before r_ready");
	assert property (@(posedge munoc_port_30) disable iff (!munoc_port_16)
		r_valid && !r_ready |=> r_data == r_data_prev)
		else report_mismatch("r_data", $sampled(r_data), $sampled(r_data_prev));
	assert property (@(posedge munoc_port_30) disable iff (!munoc_port_16)
		rd_outstanding >= route_depth |-> !ar_ready)
		else report_failure("read accepted with four reads outstanding");

	// ******************************
	// Stimulus
	// ******************************
	initial
	begin
		logic [31:0] rnd;
		munoc_port_16 = 1'b1;
		aw_id = '0;
		aw_addr = '0;
		aw_valid = 1'b0;
		w_data = '0;
		w_strb = '0;
		w_valid = 1'b0;
		b_ready = 1'b1;
		ar_id = '0;
		ar_addr = '0;
		ar_valid = 1'b0;
		r_ready = 1'b1;
		axi_hold = 1'b0;
		apb_hold = 1'b0;
		no_apb = 1'b0;
		exp_paddr = '0;
		exp_pwdata = '0;
		exp_w_addr = '0;
		exp_w_data = '0;
		exp_w_strb = '0;
		#2 munoc_port_16 = 1'b0;
		repeat (10) @(posedge munoc_port_30);
		#1 munoc_port_16 = 1'b1;
		finish_test("reset");

		// Tagged writes with a slow APB slave on the first one
		for (int i = 0; i < 3; i++)
			wr_addr[i] = make_addr(1'b1);
		apb_hold = 1'b1;
		fork
			send_write(4'h1, wr_addr[0], next_random());
			begin
				repeat (6) @(posedge munoc_port_30);
				#1 apb_hold = 1'b0;
			end
		join
		drain_responses();
		for (int i = 1; i < 3; i++)
		begin
			send_write(id_w'(i + 1), wr_addr[i], next_random());
			drain_responses();
		end
		rnd = next_random();
		send_write(4'h7, {bridge_tag, rnd[27:8], 8'hfc}, next_random());
		drain_responses();
		finish_test("tagged write");

		for (int i = 0; i < 3; i++)
			send_read(id_w'(i + 8), wr_addr[i]);
		drain_responses();
		finish_test("tagged read");

		no_apb = 1'b1;
		for (int i = 0; i < 3; i++)
			send_write(id_w'(i + 4), make_addr(1'b0), next_random());
		for (int i = 0; i < 3; i++)
			send_read(id_w'(i + 12), make_addr(1'b0));
		drain_responses();
		no_apb = 1'b0;
		finish_test("untagged requests");

		for (int i = 0; i < 6; i++)
		begin
			if (i % 2 == 0)
				send_read(id_w'(i), wr_addr[i / 2]);
			else
				send_read(id_w'(i), make_addr(1'b0));
		end
		drain_responses();
		finish_test("response order");

		// Upstream stall and then downstream stall with a fifth read waiting
		r_ready = 1'b0;
		send_read(4'h2, make_addr(1'b0));
		while (!r_valid)
			@(negedge munoc_port_30);
		repeat (5) @(posedge munoc_port_30);
		#1 r_ready = 1'b1;
		drain_responses();
		axi_hold = 1'b1;
		for (int i = 0; i < 4; i++)
			send_read(id_w'(i + 3), make_addr(1'b0));
		fork
			send_read(4'h9, make_addr(1'b0));
			begin
				repeat (10) @(posedge munoc_port_30);
				#1 axi_hold = 1'b0;
			end
		join
		drain_responses();
		finish_test("back-pressure");

		$display("tests %0d, passed %0d, failed %0d, check errors %0d",
			test_count, test_count - fail_count, fail_count, err_count);
		if (err_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
src/axi_apb_split_pkg.sv
src/route_fifo.sv
src/write_path.sv
src/read_path.sv
src/apb_bridge.sv
src/axi_apb_split.sv
testbench/tb_slave_models.sv
testbench/tb_axi_apb_split.sv
